// File: design/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// PC and memory index geometry
`define FETCH_PC_W            48
`define FETCH_IDX_MSB         21      // Top PC bit of the line index
`define FETCH_IDX_LSB         3       // Bottom PC bit of the line index

// Line geometry
`define FETCH_LINE_BYTES      64      // Also the PC step per line
`define FETCH_INST_W          32
`define FETCH_INSTS_PER_LINE  16
`define FETCH_LINE_W          (`FETCH_INST_W * `FETCH_INSTS_PER_LINE)

// Configuration register reset values
`define FETCH_BOOT_RST        48'h0000_0000_1000
`define FETCH_VEC_RST         48'h0000_0000_0400

`endif

// File: design/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

    // Byte address of an instruction or line
    typedef logic [`FETCH_PC_W-1:0] pc_t;

    // Memory line index, PC bits IDX_MSB..IDX_LSB
    typedef logic [`FETCH_IDX_MSB-`FETCH_IDX_LSB:0] line_idx_t;

    // Branch or restart request
    typedef struct packed {
        logic valid;
        pc_t  target;   // New PC
    } redirect_t;

    // Read data returned by the line memory
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_LINE_W-1:0] line;   // Word 0 in the low bits
    } mem_rsp_t;

    // One instruction handed to the consumer
    typedef struct packed {
        logic [`FETCH_INST_W-1:0] word;
        pc_t                      pc;
    } inst_t;

    // Configuration register select
    typedef enum logic [1:0] {
        CFG_BOOT    = 2'd0,   // Boot address
        CFG_VEC     = 2'd1,   // Interrupt vector
        CFG_RESTART = 2'd2    // Restart command, no storage
    } cfg_sel_t;

endpackage

// File: design/fetch_cfg_regs.sv
`include "fetch_defs.svh"

module fetch_cfg_regs import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // Register write port
    input  logic      cfg_wr,
    input  cfg_sel_t  cfg_sel,
    input  pc_t       cfg_wdata,

    // To pc_ctrl
    output pc_t       boot_addr,
    output pc_t       irq_vector,
    output redirect_t restart
);

    logic restart_valid;    // One-cycle restart strobe
    pc_t  restart_target;   // Boot address sampled at the command write
    logic restart_cmd;

    assign restart_cmd = cfg_wr && (cfg_sel == CFG_RESTART);

    // Address registers, new value visible next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            boot_addr  <= `FETCH_BOOT_RST;
            irq_vector <= `FETCH_VEC_RST;
        end else if (cfg_wr) begin
            case (cfg_sel)
                CFG_BOOT: boot_addr  <= cfg_wdata;
                CFG_VEC:  irq_vector <= cfg_wdata;
                default:  ;                          // Restart handled below
            endcase
        end
    end

    // Restart command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            restart_valid <= 1'b0;
        end else begin
            restart_valid <= restart_cmd;            // Self-clearing pulse
        end
    end

    // Target is the boot address as it stands when the command lands,
    // so a boot write in the same cycle is not yet seen
    always_ff @(posedge clk) begin
        if (restart_cmd) begin
            restart_target <= boot_addr;
        end
    end

    assign restart = '{valid: restart_valid, target: restart_target};

endmodule

// File: design/pc_ctrl.sv
`include "fetch_defs.svh"

module pc_ctrl import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // Boot, interrupt and restart from the config block
    input  pc_t       boot_addr,
    input  logic      irq,
    input  pc_t       irq_vector,
    input  redirect_t restart,

    // Branch from the execute side
    input  redirect_t branch,

    // Instruction buffer side
    input  logic      fetch_inst,       // Pulse, buffer wants the next line
    output logic      can_fetch_inst,   // Current line delivered
    output logic      clear_ibuffer,    // One-cycle flush
    output pc_t       line_pc,

    // Line fetch arbiter side
    output logic      pc_index_valid,
    output line_idx_t pc_index,
    input  logic      pc_index_ready    // Line read complete
);

    pc_t       pc;
    redirect_t redir;   // Restart and branch merged

    // Restart beats branch
    always_comb begin
        if (restart.valid) begin
            redir = restart;
        end else begin
            redir = branch;
        end
    end

    assign pc_index = pc[`FETCH_IDX_MSB:`FETCH_IDX_LSB];
    assign line_pc  = pc;

    // Priority: irq, redirect, fetch, completion
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc             <= boot_addr;   // Nothing requested until a redirect
            pc_index_valid <= 1'b0;
            can_fetch_inst <= 1'b0;
            clear_ibuffer  <= 1'b0;
        end else begin
            clear_ibuffer <= 1'b0;   // Flush lasts a single cycle
            if (irq) begin
                pc             <= irq_vector;
                pc_index_valid <= 1'b1;
                can_fetch_inst <= 1'b0;
                clear_ibuffer  <= 1'b1;
            end else if (redir.valid) begin
                pc             <= redir.target;
                pc_index_valid <= 1'b1;
                can_fetch_inst <= 1'b0;
                clear_ibuffer  <= 1'b1;
            end else if (fetch_inst) begin
                pc             <= pc + pc_t'(`FETCH_LINE_BYTES);   // Next line
                pc_index_valid <= 1'b1;
                can_fetch_inst <= 1'b0;
            end else if (pc_index_ready) begin
                pc_index_valid <= 1'b0;   // Read done
                can_fetch_inst <= 1'b1;   // Buffer may ask again once drained
            end
        end
    end

endmodule

// File: design/line_fetch_arb.sv
`include "fetch_defs.svh"

module line_fetch_arb import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    // From pc_ctrl
    input  logic                     pc_index_valid,
    input  line_idx_t                pc_index,
    input  logic                     clear_ibuffer,
    output logic                     pc_index_ready,

    // Line memory port
    output logic                     mem_req,     // One-cycle read strobe
    output line_idx_t                mem_index,
    input  mem_rsp_t                 mem_rsp,

    // To inst_buffer
    output logic                     line_load,
    output logic [`FETCH_LINE_W-1:0] line_data
);

    typedef enum logic [1:0] {
        ARB_IDLE,      // No read in flight
        ARB_WAIT,      // Read issued, waiting on mem_rsp
        ARB_DELIVER,   // Line handed to the buffer this cycle
        ARB_HOLD       // Wait for pc_ctrl to drop the index
    } arb_state_e;

    arb_state_e state;
    logic       stale;       // Flush seen while the read was pending
    logic       rsp_drop;

    // Flush in the response cycle also kills the data
    assign rsp_drop = stale || clear_ibuffer;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ARB_IDLE;
            stale   <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            mem_req <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    stale <= 1'b0;
                    if (pc_index_valid) begin
                        mem_req <= 1'b1;   // Issue next cycle
                        state   <= ARB_WAIT;
                    end
                end
                ARB_WAIT: begin
                    if (mem_rsp.valid) begin
                        stale <= 1'b0;
                        state <= rsp_drop ? ARB_IDLE : ARB_DELIVER;   // Idle reissues
                    end else if (clear_ibuffer) begin
                        stale <= 1'b1;
                    end
                end
                ARB_DELIVER: state <= clear_ibuffer ? ARB_IDLE : ARB_HOLD;
                ARB_HOLD: begin
                    if (!pc_index_valid || clear_ibuffer) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Read address and returned line
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && pc_index_valid) begin
            mem_index <= pc_index;
        end
        if (state == ARB_WAIT && mem_rsp.valid) begin
            line_data <= mem_rsp.line;
        end
    end

    // A flush in the deliver cycle means the line is already old
    assign pc_index_ready = (state == ARB_DELIVER) && !clear_ibuffer;
    assign line_load      = (state == ARB_DELIVER) && !clear_ibuffer;

endmodule

// File: design/inst_buffer.sv
`include "fetch_defs.svh"

module inst_buffer import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    // Line from the arbiter
    input  logic                     line_load,
    input  logic [`FETCH_LINE_W-1:0] line_data,
    input  pc_t                      line_pc,      // PC of word 0

    // pc_ctrl side
    input  logic                     clear_ibuffer,
    input  logic                     can_fetch_inst,
    output logic                     fetch_inst,

    // Consumer side
    output logic                     inst_valid,
    output inst_t                    inst,
    input  logic                     inst_take
);

    localparam int PTR_W = $clog2(`FETCH_INSTS_PER_LINE);
    localparam logic [PTR_W-1:0] LAST_WORD = PTR_W'(`FETCH_INSTS_PER_LINE - 1);
    localparam int INST_BYTES = `FETCH_INST_W / 8;

    logic [`FETCH_LINE_W-1:0] line_q;
    pc_t                      base_pc;
    logic [PTR_W-1:0]         ptr;        // Next word to hand out
    logic                     full;       // Line holds untaken words
    logic                     req_pend;   // fetch_inst sent, line not back yet
    logic                     take;

    assign take = inst_take && full;   // Takes on an empty buffer are ignored

    // Control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr      <= '0;
            full     <= 1'b0;
            req_pend <= 1'b0;
        end else if (clear_ibuffer) begin
            ptr      <= '0;   // Flush wins over everything
            full     <= 1'b0;
            req_pend <= 1'b0;
        end else if (line_load) begin
            ptr      <= '0;   // Always start at word 0
            full     <= 1'b1;
            req_pend <= 1'b0;
        end else begin
            if (take) begin
                ptr <= ptr + 1'b1;
                if (ptr == LAST_WORD) begin
                    full <= 1'b0;   // Sixteenth take drains the line
                end
            end
            if (fetch_inst) begin
                req_pend <= 1'b1;
            end
        end
    end

    // Line payload
    always_ff @(posedge clk) begin
        if (line_load) begin
            line_q  <= line_data;
            base_pc <= line_pc;
        end
    end

    // Ask once per empty period
    assign fetch_inst = !full && can_fetch_inst && !req_pend;

    assign inst_valid = full;
    assign inst.word  = line_q[ptr * `FETCH_INST_W +: `FETCH_INST_W];
    assign inst.pc    = base_pc + pc_t'(ptr) * pc_t'(INST_BYTES);   // Word offset in bytes

endmodule

// File: design/fetch_unit.sv
`include "fetch_defs.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // Configuration
    input  logic      cfg_wr,
    input  cfg_sel_t  cfg_sel,
    input  pc_t       cfg_wdata,

    // Redirects
    input  logic      irq,         // One-cycle pulse
    input  redirect_t branch,      // Valid for one cycle

    // Line memory
    output logic      mem_req,
    output line_idx_t mem_index,
    input  mem_rsp_t  mem_rsp,

    // Instruction stream
    output logic      inst_valid,
    output inst_t     inst,
    input  logic      inst_take
);

    pc_t                      boot_addr;
    pc_t                      irq_vector;
    redirect_t                restart;
    logic                     can_fetch_inst;
    logic                     clear_ibuffer;
    pc_t                      line_pc;
    logic                     pc_index_valid;
    line_idx_t                pc_index;
    logic                     pc_index_ready;
    logic                     fetch_inst;
    logic                     line_load;
    logic [`FETCH_LINE_W-1:0] line_data;

    // Boot, vector and restart registers
    fetch_cfg_regs cfg_regs_inst (
        .clk, .rst_n, .cfg_wr, .cfg_sel, .cfg_wdata,
        .boot_addr, .irq_vector, .restart
    );

    // PC and redirect priority
    pc_ctrl pc_ctrl_inst (
        .clk, .rst_n, .boot_addr, .irq, .irq_vector, .restart, .branch,
        .fetch_inst, .can_fetch_inst, .clear_ibuffer, .line_pc,
        .pc_index_valid, .pc_index, .pc_index_ready
    );

    // One read per line index
    line_fetch_arb line_fetch_arb_inst (
        .clk, .rst_n, .pc_index_valid, .pc_index, .clear_ibuffer, .pc_index_ready,
        .mem_req, .mem_index, .mem_rsp, .line_load, .line_data
    );

    // Line to instruction stream
    inst_buffer inst_buffer_inst (
        .clk, .rst_n, .line_load, .line_data, .line_pc, .clear_ibuffer,
        .can_fetch_inst, .fetch_inst, .inst_valid, .inst, .inst_take
    );

endmodule

// File: sim/fetch_unit_assert.sv
`include "fetch_defs.svh"

module fetch_unit_assert import fetch_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     mem_req,
    input mem_rsp_t mem_rsp,
    input logic     fetch_inst,
    input logic     can_fetch_inst,
    input logic     clear_ibuffer,
    input logic     line_load,
    input logic     inst_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    logic rd_open;           // Read issued and not yet answered
    int   violations = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_open <= 1'b0;
        end else if (mem_req) begin
            rd_open <= 1'b1;
        end else if (mem_rsp.valid) begin
            rd_open <= 1'b0;     // Answer closes the read
        end
    end

    single_read: assert property (@(posedge clk) disable iff (!rst_n) mem_req |-> !rd_open)
        else begin
            violations++;
            $error("mem_req issued while a read is outstanding");
        end

    // One request per delivered line, never two cycles in a row
    fetch_gated: assert property (@(posedge clk) disable iff (!rst_n)
                                  fetch_inst |-> can_fetch_inst && !$past(fetch_inst))
        else begin
            violations++;
            $error("fetch_inst raised without can_fetch_inst or held for two cycles");
        end

    // Buffer must be empty right after a flush and no old line may follow
    flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
                                    clear_ibuffer |=> !inst_valid && !line_load)
        else begin
            violations++;
            $error("inst_valid or line_load high in the cycle after clear_ibuffer");
        end

endmodule

bind fetch_unit fetch_unit_assert fetch_unit_assert_inst (
    .clk, .rst_n, .mem_req, .mem_rsp, .fetch_inst, .can_fetch_inst, .clear_ibuffer,
    .line_load, .inst_valid
);

// File: sim/fetch_unit_tb.sv
`include "fetch_defs.svh"

module fetch_unit_tb import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam time         PERIOD     = 40ns;
    localparam time         DRV_DLY    = 2ns;     // Input skew after the rising edge
    localparam logic [31:0] SEED       = 32'h5c98_8787;
    localparam int          TEST_LINES = 64;      // Upper bound on lines fetched in the run
    localparam int          LINE_CYCLES = 4 * `FETCH_INSTS_PER_LINE + 8 + 16;  // Slow take, 8 latency
    localparam int          WATCHDOG_CYCLES = TEST_LINES * LINE_CYCLES + 2000;  // Plus idle phases

    typedef enum logic [1:0] {M_IDLE, M_FLUSH, M_SYNC} model_mode_e;

    logic        clk, rst_n, cfg_wr, irq, mem_req, inst_valid, inst_take;
    cfg_sel_t    cfg_sel;
    pc_t         cfg_wdata;
    redirect_t   branch;
    line_idx_t   mem_index;
    mem_rsp_t    mem_rsp;
    inst_t       inst;

    logic [31:0] rng_main = SEED, rng_take = SEED, rng_mem = SEED;   // One LFSR per process
    model_mode_e mode = M_IDLE;
    pc_t         pend_pc;                         // Target of the redirect in flight
    pc_t         exp_pc, fetch_pc;                // Next instruction, next line read
    pc_t         model_boot = `FETCH_BOOT_RST;
    pc_t         model_vec  = `FETCH_VEC_RST;
    int          sync_cnt = 0;                    // Instructions checked so far
    int          err_inst = 0, err_index = 0, err_other = 0, err_assert = 0;

    fetch_unit fetch_unit_inst (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
    endfunction

    // n fresh bits, one shift per bit
    task automatic draw(inout logic [31:0] st, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            st  = lfsr_next(st);
            val = {val[30:0], st[0]};
        end
    endtask

    // Memory contents, word w of line idx
    function automatic logic [31:0] mem_word(input line_idx_t idx, input logic [3:0] w);
        return {w, idx, 9'd0} ^ {idx[8:0], ~w, idx};
    endfunction

    function automatic line_idx_t line_of(input pc_t pc);
        pc_t base;
        base = pc - (pc % pc_t'(`FETCH_LINE_BYTES));   // Start of the line
        return base[`FETCH_IDX_MSB:`FETCH_IDX_LSB];
    endfunction

    task automatic compare_inst(input inst_t exp, input inst_t got);
        if (got.word !== exp.word) begin
            err_inst++;
            $display("CHECK FAILED t=%0t inst.word exp=%h got=%h", $time, exp.word, got.word);
        end
        if (got.pc !== exp.pc) begin
            err_inst++;
            $display("CHECK FAILED t=%0t inst.pc exp=%h got=%h", $time, exp.pc, got.pc);
        end
    endtask

    task automatic compare_index(input line_idx_t exp, input line_idx_t got);
        if (got !== exp) begin
            err_index++;
            $display("CHECK FAILED t=%0t mem_index exp=%h got=%h", $time, exp, got);
        end
    endtask

    task automatic flag_error(input string what);
        err_other++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic cfg_write(input cfg_sel_t sel, input pc_t data);
        cfg_wr    = 1'b1;
        cfg_sel   = sel;
        cfg_wdata = data;
        case (sel)
            CFG_BOOT: model_boot = data;
            CFG_VEC:  model_vec  = data;
            default: begin
                pend_pc = model_boot;             // Restart goes to the boot address
                mode    = M_FLUSH;
            end
        endcase
        next_cycle();
        cfg_wr = 1'b0;
    endtask

    task automatic send_redirect(input pc_t tgt, input logic with_irq, input logic with_br);
        irq     = with_irq;
        branch  = '{valid: with_br, target: tgt};
        pend_pc = with_irq ? model_vec : tgt;     // Interrupt wins over branch
        mode    = M_FLUSH;
        next_cycle();
        irq    = 1'b0;
        branch = '0;
    endtask

    task automatic wait_insts(input int n);
        int goal;
        goal = sync_cnt + n;
        while (sync_cnt < goal) next_cycle();
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reference model, sampled mid-cycle
    always @(negedge clk) begin
        inst_t exp;
        if (rst_n) begin
            if (mode == M_IDLE && (mem_req || inst_valid)) begin
                flag_error("fetch activity before any restart");
            end
            if (mode == M_SYNC && inst_valid && inst_take) begin
                exp.pc   = exp_pc;
                exp.word = mem_word(line_of(exp_pc), 4'((exp_pc % `FETCH_LINE_BYTES) / 4));
                compare_inst(exp, inst);
                exp_pc = exp_pc + pc_t'(4);
                sync_cnt++;
            end
            if (mode == M_SYNC && mem_req) begin
                compare_index(line_of(fetch_pc), mem_index);
                fetch_pc = fetch_pc + pc_t'(`FETCH_LINE_BYTES);   // Lines stay sequential
            end
            if (fetch_unit_inst.clear_ibuffer) begin   // Old stream ends here
                if (mode != M_FLUSH) begin
                    flag_error("buffer flushed without a redirect");
                end
                mode     = M_SYNC;
                exp_pc   = pend_pc;
                fetch_pc = pend_pc;
            end
        end
    end

    // Line memory, one read at a time, latency 1 to 8
    initial begin
        logic [31:0] lat;
        line_idx_t   idx;
        mem_rsp = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                idx = mem_index;
                draw(rng_mem, 3, lat);
                repeat (lat + 1) @(posedge clk);
                #DRV_DLY;
                mem_rsp.valid = 1'b1;
                for (int w = 0; w < `FETCH_INSTS_PER_LINE; w++) begin
                    mem_rsp.line[w * `FETCH_INST_W +: `FETCH_INST_W] = mem_word(idx, 4'(w));
                end
                next_cycle();
                mem_rsp = '0;
            end
        end
    end

    // Consumer with random gaps of 0 to 3 cycles
    initial begin
        logic [31:0] gap;
        inst_take = 1'b0;
        @(posedge rst_n);
        forever begin
            draw(rng_take, 2, gap);
            inst_take = 1'b0;
            repeat (gap) next_cycle();
            inst_take = 1'b1;
            next_cycle();
        end
    end

    initial begin
        logic [31:0] r;
        pc_t         tgt;
        rst_n     = 1'b0;
        cfg_wr    = 1'b0;
        cfg_sel   = CFG_BOOT;
        cfg_wdata = '0;
        irq       = 1'b0;
        branch    = '0;
        repeat (10) next_cycle();
        rst_n = 1'b1;
        repeat (50) next_cycle();                 // Must stay quiet without a restart
        cfg_write(CFG_RESTART, '0);
        wait_insts(3 * `FETCH_INSTS_PER_LINE);    // Boot line and two sequential lines
        for (int i = 0; i < 12; i++) begin
            if (i % 2 == 0) begin
                do @(negedge clk); while (!mem_req);   // Branch with a read outstanding
                next_cycle();
            end else begin
                draw(rng_main, 6, r);             // Anywhere in the stream
                repeat (r) next_cycle();
            end
            draw(rng_main, 16, r);
            tgt = pc_t'(r[15:0]) * pc_t'(`FETCH_LINE_BYTES);
            send_redirect(tgt, 1'b0, 1'b1);
            draw(rng_main, 4, r);
            wait_insts(int'(r) + 1);
        end
        send_redirect(pc_t'(48'h0000_0003_0000), 1'b1, 1'b1);   // irq and branch together
        wait_insts(20);
        cfg_write(CFG_BOOT, pc_t'(48'h0000_0012_3440));
        cfg_write(CFG_VEC, pc_t'(48'h0000_0000_8800));
        cfg_write(CFG_RESTART, '0);
        wait_insts(20);
        send_redirect('0, 1'b1, 1'b0);
        wait_insts(2 * `FETCH_INSTS_PER_LINE);
        err_assert = fetch_unit_inst.fetch_unit_assert_inst.violations;
        $display("Errors: inst=%0d index=%0d other=%0d assert=%0d",
                 err_inst, err_index, err_other, err_assert);
        if (err_inst + err_index + err_other + err_assert == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the instruction stream stalled",
                 WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+design
design/fetch_pkg.sv
design/fetch_cfg_regs.sv
design/pc_ctrl.sv
design/line_fetch_arb.sv
design/inst_buffer.sv
design/fetch_unit.sv
sim/fetch_unit_assert.sv
sim/fetch_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the fetch unit testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module fetch_unit_tb \
    -f filelist.f -o fetch_unit_sim > build.log 2>&1 \
    && ./obj_dir/fetch_unit_sim > sim.log 2>&1 \
    || echo "Build or run stopped with an error, see build.log and sim.log"
grep -q "Result: PASSED" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }
